// ==== design/csr_pkg.sv ====
// CSR unit shared definitions
`default_nettype none

package csr_pkg;

    parameter int XLEN = 32;

    typedef logic [XLEN-1:0]   csr_data_t;   // one register word
    typedef logic [11:0]       csr_addr_t;   // csr address space
    typedef logic [2*XLEN-1:0] csr_dword_t;  // 64-bit counter value

    // trap setup and handling
    parameter csr_addr_t CSR_MSTATUS  = 12'h300;
    parameter csr_addr_t CSR_MISA     = 12'h301;
    parameter csr_addr_t CSR_MIE      = 12'h304;
    parameter csr_addr_t CSR_MTVEC    = 12'h305;
    parameter csr_addr_t CSR_MSCRATCH = 12'h340;
    parameter csr_addr_t CSR_MEPC     = 12'h341;
    parameter csr_addr_t CSR_MCAUSE   = 12'h342;
    parameter csr_addr_t CSR_MTVAL    = 12'h343;

    // machine counters, low and high halves
    parameter csr_addr_t CSR_MCYCLE    = 12'hB00;
    parameter csr_addr_t CSR_MINSTRET  = 12'hB02;
    parameter csr_addr_t CSR_MCYCLEH   = 12'hB80;
    parameter csr_addr_t CSR_MINSTRETH = 12'hB82;

    // user-level timer, read only
    parameter csr_addr_t CSR_TIME  = 12'hC01;
    parameter csr_addr_t CSR_TIMEH = 12'hC81;

    parameter int MSTATUS_MIE_BIT = 3;  // global interrupt enable

endpackage

`default_nettype wire

// ==== design/csr_ifs.sv ====
// CSR write bus and register state
`timescale 1ns/1ps
`default_nettype none

interface csr_wr_if;

    logic                 ex_we;
    csr_pkg::csr_addr_t   ex_addr;
    csr_pkg::csr_data_t   ex_data;
    logic                 clint_we;
    csr_pkg::csr_addr_t   clint_addr;
    csr_pkg::csr_data_t   clint_data;

    modport sink    (input ex_we, ex_addr, ex_data, clint_we, clint_addr, clint_data);
    modport monitor (input ex_we, ex_addr, ex_data, clint_we, clint_addr, clint_data);

endinterface

interface csr_state_if;

    csr_pkg::csr_data_t  mstatus;
    csr_pkg::csr_data_t  mie;
    csr_pkg::csr_data_t  mtvec;
    csr_pkg::csr_data_t  mscratch;
    csr_pkg::csr_data_t  mepc;
    csr_pkg::csr_data_t  mcause;
    csr_pkg::csr_data_t  mtval;
    csr_pkg::csr_dword_t mcycle;
    csr_pkg::csr_dword_t minstret;
    csr_pkg::csr_dword_t time_val;  // "time" is reserved

    modport trap_src (output mstatus, mie, mtvec, mscratch, mepc, mcause, mtval);
    modport cnt_src  (output mcycle, minstret, time_val);
    modport reader   (input mstatus, mie, mtvec, mscratch, mepc, mcause, mtval,
                      input mcycle, minstret, time_val);

endinterface

`default_nettype wire

// ==== design/csr_trap_regs.sv ====
// Machine trap registers
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
    input  logic       clk,
    input  logic       rst_n_i,
    csr_wr_if.sink     wr,
    csr_state_if.trap_src st
);

    localparam int TRAP_REGS = 7;

    // slot index to csr address
    function automatic csr_pkg::csr_addr_t trap_addr(input int idx);
        case (idx)
            0:       trap_addr = csr_pkg::CSR_MSTATUS;
            1:       trap_addr = csr_pkg::CSR_MIE;
            2:       trap_addr = csr_pkg::CSR_MTVEC;
            3:       trap_addr = csr_pkg::CSR_MSCRATCH;
            4:       trap_addr = csr_pkg::CSR_MEPC;
            5:       trap_addr = csr_pkg::CSR_MCAUSE;
            6:       trap_addr = csr_pkg::CSR_MTVAL;
            default: trap_addr = '0;
        endcase
    endfunction

    genvar g;
    generate
        for (g = 0; g < TRAP_REGS; g++) begin : g_reg
            localparam csr_pkg::csr_addr_t ADDR = trap_addr(g);

            logic               ex_hit;
            logic               clint_hit;
            csr_pkg::csr_data_t value_q;

            assign ex_hit    = wr.ex_we && (wr.ex_addr == ADDR);
            assign clint_hit = wr.clint_we && (wr.clint_addr == ADDR);

            // execute stage wins a same-register collision
            always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    value_q <= '0;
                end else if (ex_hit) begin
                    value_q <= wr.ex_data;
                end else if (clint_hit) begin
                    value_q <= wr.clint_data;
                end
            end
        end
    endgenerate

    assign st.mstatus  = g_reg[0].value_q;
    assign st.mie      = g_reg[1].value_q;
    assign st.mtvec    = g_reg[2].value_q;
    assign st.mscratch = g_reg[3].value_q;
    assign st.mepc     = g_reg[4].value_q;
    assign st.mcause   = g_reg[5].value_q;
    assign st.mtval    = g_reg[6].value_q;

endmodule

`default_nettype wire

// ==== design/csr_counters.sv ====
// Cycle, instret and time counters
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         inst_valid_i,
    csr_wr_if.sink       wr,
    csr_state_if.cnt_src st
);

    localparam int W = csr_pkg::XLEN;

    csr_pkg::csr_dword_t time_q;

    // slot 0 is mcycle, slot 1 is minstret
    genvar g;
    generate
        for (g = 0; g < 2; g++) begin : g_cnt
            localparam csr_pkg::csr_addr_t LO_ADDR =
                (g == 0) ? csr_pkg::CSR_MCYCLE : csr_pkg::CSR_MINSTRET;
            localparam csr_pkg::csr_addr_t HI_ADDR =
                (g == 0) ? csr_pkg::CSR_MCYCLEH : csr_pkg::CSR_MINSTRETH;

            logic                lo_ex;
            logic                lo_clint;
            logic                hi_ex;
            logic                hi_clint;
            logic                count_en;
            csr_pkg::csr_data_t  lo_next;
            csr_pkg::csr_data_t  hi_next;
            csr_pkg::csr_dword_t cnt_q;

            assign lo_ex    = wr.ex_we && (wr.ex_addr == LO_ADDR);
            assign lo_clint = wr.clint_we && (wr.clint_addr == LO_ADDR);
            assign hi_ex    = wr.ex_we && (wr.ex_addr == HI_ADDR);
            assign hi_clint = wr.clint_we && (wr.clint_addr == HI_ADDR);

            assign count_en = (g == 0) ? 1'b1 : inst_valid_i;

            // each half picks ex first, else clint, else holds
            assign lo_next = lo_ex    ? wr.ex_data    :
                             lo_clint ? wr.clint_data : cnt_q[W-1:0];
            assign hi_next = hi_ex    ? wr.ex_data    :
                             hi_clint ? wr.clint_data : cnt_q[2*W-1:W];

            always_ff @(posedge clk or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    cnt_q <= '0;
                end else if (lo_ex || lo_clint || hi_ex || hi_clint) begin
                    cnt_q <= {hi_next, lo_next};  // load replaces the increment
                end else if (count_en) begin
                    cnt_q <= cnt_q + 1'b1;
                end
            end
        end
    endgenerate

    // free-running, no write path
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            time_q <= '0;
        end else begin
            time_q <= time_q + 1'b1;
        end
    end

    assign st.mcycle   = g_cnt[0].cnt_q;
    assign st.minstret = g_cnt[1].cnt_q;
    assign st.time_val = time_q;

endmodule

`default_nettype wire

// ==== design/csr_read_port.sv ====
// CSR read port with write bypass
`timescale 1ns/1ps
`default_nettype none

module csr_read_port #(
    parameter csr_pkg::csr_data_t MISA_VALUE = 32'h4000_1100
) (
    input  logic               we_i,
    input  csr_pkg::csr_addr_t waddr_i,
    input  csr_pkg::csr_data_t wdata_i,
    input  csr_pkg::csr_addr_t raddr_i,
    csr_state_if.reader        st,
    output csr_pkg::csr_data_t rdata_o
);

    localparam int W = csr_pkg::XLEN;

    csr_pkg::csr_data_t stored;
    logic               writable;  // address has a write path
    logic               bypass;

    always_comb begin
        writable = 1'b1;
        case (raddr_i)
            csr_pkg::CSR_MSTATUS:   stored = st.mstatus;
            csr_pkg::CSR_MIE:       stored = st.mie;
            csr_pkg::CSR_MTVEC:     stored = st.mtvec;
            csr_pkg::CSR_MSCRATCH:  stored = st.mscratch;
            csr_pkg::CSR_MEPC:      stored = st.mepc;
            csr_pkg::CSR_MCAUSE:    stored = st.mcause;
            csr_pkg::CSR_MTVAL:     stored = st.mtval;
            csr_pkg::CSR_MCYCLE:    stored = st.mcycle[W-1:0];
            csr_pkg::CSR_MCYCLEH:   stored = st.mcycle[2*W-1:W];
            csr_pkg::CSR_MINSTRET:  stored = st.minstret[W-1:0];
            csr_pkg::CSR_MINSTRETH: stored = st.minstret[2*W-1:W];
            csr_pkg::CSR_MISA: begin
                stored   = MISA_VALUE;
                writable = 1'b0;
            end
            csr_pkg::CSR_TIME: begin
                stored   = st.time_val[W-1:0];
                writable = 1'b0;
            end
            csr_pkg::CSR_TIMEH: begin
                stored   = st.time_val[2*W-1:W];
                writable = 1'b0;
            end
            default: begin
                stored   = '0;  // unknown or dropped csr
                writable = 1'b0;
            end
        endcase
    end

    // same-port write to the read address forwards in the same cycle
    assign bypass  = we_i && writable && (waddr_i == raddr_i);
    assign rdata_o = bypass ? wdata_i : stored;

endmodule

`default_nettype wire

// ==== design/csr_top.sv ====
// Machine-mode CSR unit top
`timescale 1ns/1ps
`default_nettype none

module csr_top #(
    parameter csr_pkg::csr_data_t MISA_VALUE = 32'h4000_1100  // RV32IM
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               inst_valid_i,

    // execute stage
    input  logic               ex_we_i,
    input  csr_pkg::csr_addr_t ex_raddr_i,
    input  csr_pkg::csr_addr_t ex_waddr_i,
    input  csr_pkg::csr_data_t ex_wdata_i,
    output csr_pkg::csr_data_t ex_rdata_o,

    // interrupt controller
    input  logic               clint_we_i,
    input  csr_pkg::csr_addr_t clint_raddr_i,
    input  csr_pkg::csr_addr_t clint_waddr_i,
    input  csr_pkg::csr_data_t clint_wdata_i,
    output csr_pkg::csr_data_t clint_rdata_o,

    output logic               global_int_en_o,
    output csr_pkg::csr_data_t clint_mtvec_o,
    output csr_pkg::csr_data_t clint_mepc_o,
    output csr_pkg::csr_data_t clint_mstatus_o,
    output csr_pkg::csr_data_t clint_mie_o
);

    csr_wr_if    wr_bus ();
    csr_state_if state ();

    assign wr_bus.ex_we      = ex_we_i;
    assign wr_bus.ex_addr    = ex_waddr_i;
    assign wr_bus.ex_data    = ex_wdata_i;
    assign wr_bus.clint_we   = clint_we_i;
    assign wr_bus.clint_addr = clint_waddr_i;
    assign wr_bus.clint_data = clint_wdata_i;

    csr_trap_regs trap_regs (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wr      (wr_bus.sink),
        .st      (state.trap_src)
    );

    csr_counters counters (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .wr           (wr_bus.sink),
        .st           (state.cnt_src)
    );

    csr_read_port #(.MISA_VALUE(MISA_VALUE)) ex_read (
        .we_i    (ex_we_i),
        .waddr_i (ex_waddr_i),
        .wdata_i (ex_wdata_i),
        .raddr_i (ex_raddr_i),
        .st      (state.reader),
        .rdata_o (ex_rdata_o)
    );

    csr_read_port #(.MISA_VALUE(MISA_VALUE)) clint_read (
        .we_i    (clint_we_i),
        .waddr_i (clint_waddr_i),
        .wdata_i (clint_wdata_i),
        .raddr_i (clint_raddr_i),
        .st      (state.reader),
        .rdata_o (clint_rdata_o)
    );

    // straight register views for the interrupt controller
    assign global_int_en_o = state.mstatus[csr_pkg::MSTATUS_MIE_BIT];
    assign clint_mtvec_o   = state.mtvec;
    assign clint_mepc_o    = state.mepc;
    assign clint_mstatus_o = state.mstatus;
    assign clint_mie_o     = state.mie;

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
// CSR reference model and checker
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter csr_pkg::csr_data_t MISA_VALUE = 32'h4000_1100
) (
    input logic               clk,
    input logic               rst_n_i,
    input logic               inst_valid_i,
    input logic               ex_we_i,
    input csr_pkg::csr_addr_t ex_raddr_i,
    input csr_pkg::csr_addr_t ex_waddr_i,
    input csr_pkg::csr_data_t ex_wdata_i,
    input logic               clint_we_i,
    input csr_pkg::csr_addr_t clint_raddr_i,
    input csr_pkg::csr_addr_t clint_waddr_i,
    input csr_pkg::csr_data_t clint_wdata_i,
    input csr_pkg::csr_data_t ex_rdata_i,
    input csr_pkg::csr_data_t clint_rdata_i,
    input logic               global_int_en_i,
    input csr_pkg::csr_data_t clint_mtvec_i,
    input csr_pkg::csr_data_t clint_mepc_i,
    input csr_pkg::csr_data_t clint_mstatus_i,
    input csr_pkg::csr_data_t clint_mie_i
);

    int error_count = 0;
    int check_count = 0;

    // model order is mstatus mie mtvec mscratch mepc mcause mtval
    csr_pkg::csr_addr_t  trap_addrs [7] = '{12'h300, 12'h304, 12'h305, 12'h340,
                                            12'h341, 12'h342, 12'h343};
    csr_pkg::csr_data_t  trap_q [7];
    csr_pkg::csr_dword_t mcycle_q;
    csr_pkg::csr_dword_t minstret_q;
    csr_pkg::csr_dword_t time_q;

    // expected read value for one port under its own same-cycle write
    function automatic csr_pkg::csr_data_t expected_read(input csr_pkg::csr_addr_t raddr,
            input logic we, input csr_pkg::csr_addr_t waddr, input csr_pkg::csr_data_t wdata);
        csr_pkg::csr_data_t val;
        logic               rw;
        val = '0;
        rw  = 1'b1;
        for (int i = 0; i < 7; i++)
            if (raddr == trap_addrs[i]) val = trap_q[i];
        case (raddr)
            12'hB00: val = mcycle_q[31:0];
            12'hB80: val = mcycle_q[63:32];
            12'hB02: val = minstret_q[31:0];
            12'hB82: val = minstret_q[63:32];
            12'h301: begin
                val = MISA_VALUE;
                rw  = 1'b0;
            end
            12'hC01: begin
                val = time_q[31:0];
                rw  = 1'b0;
            end
            12'hC81: begin
                val = time_q[63:32];
                rw  = 1'b0;
            end
            12'h300, 12'h304, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343: rw = 1'b1;
            default: rw = 1'b0;  // unknown reads zero
        endcase
        if (rw && we && waddr == raddr) val = wdata;
        return val;
    endfunction

    task automatic check_value(input string name, input csr_pkg::csr_data_t exp,
                               input csr_pkg::csr_data_t act);
        check_count++;
        if (exp !== act) begin
            error_count++;
            $display("[ERROR] %0t ns %s expected %08h got %08h", $time, name, exp, act);
        end
    endtask

    // half loads win over counting and ex over clint
    task automatic step_counter(inout csr_pkg::csr_dword_t cnt, input csr_pkg::csr_addr_t lo_a,
                                input csr_pkg::csr_addr_t hi_a, input logic en);
        csr_pkg::csr_data_t lo;
        csr_pkg::csr_data_t hi;
        logic               loaded;
        lo     = cnt[31:0];
        hi     = cnt[63:32];
        loaded = 1'b0;
        if (clint_we_i && clint_waddr_i == lo_a) begin
            lo     = clint_wdata_i;
            loaded = 1'b1;
        end
        if (clint_we_i && clint_waddr_i == hi_a) begin
            hi     = clint_wdata_i;
            loaded = 1'b1;
        end
        if (ex_we_i && ex_waddr_i == lo_a) begin
            lo     = ex_wdata_i;
            loaded = 1'b1;
        end
        if (ex_we_i && ex_waddr_i == hi_a) begin
            hi     = ex_wdata_i;
            loaded = 1'b1;
        end
        if (loaded) cnt = {hi, lo};
        else if (en) cnt = cnt + 64'd1;
    endtask

    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 7; i++) trap_q[i] = '0;
            mcycle_q   = '0;
            minstret_q = '0;
            time_q     = '0;
        end else begin
            check_value("ex_rdata_o", expected_read(ex_raddr_i, ex_we_i, ex_waddr_i,
                        ex_wdata_i), ex_rdata_i);
            check_value("clint_rdata_o", expected_read(clint_raddr_i, clint_we_i,
                        clint_waddr_i, clint_wdata_i), clint_rdata_i);
            check_value("global_int_en_o", {31'b0, trap_q[0][3]}, {31'b0, global_int_en_i});
            check_value("clint_mstatus_o", trap_q[0], clint_mstatus_i);
            check_value("clint_mie_o", trap_q[1], clint_mie_i);
            check_value("clint_mtvec_o", trap_q[2], clint_mtvec_i);
            check_value("clint_mepc_o", trap_q[4], clint_mepc_i);
            for (int i = 0; i < 7; i++) begin
                if (ex_we_i && ex_waddr_i == trap_addrs[i]) trap_q[i] = ex_wdata_i;
                else if (clint_we_i && clint_waddr_i == trap_addrs[i]) trap_q[i] = clint_wdata_i;
            end
            step_counter(mcycle_q, 12'hB00, 12'hB80, 1'b1);
            step_counter(minstret_q, 12'hB02, 12'hB82, inst_valid_i);
            time_q = time_q + 64'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verification/csr_assertions.sv ====
// CSR top level assertions
`timescale 1ns/1ps
`default_nettype none

module csr_assertions (
    input logic               clk,
    input logic               rst_n_i,
    input logic               ex_we_i,
    input csr_pkg::csr_addr_t ex_waddr_i,
    input logic               clint_we_i,
    input csr_pkg::csr_addr_t clint_waddr_i,
    input csr_pkg::csr_data_t ex_rdata_o,
    input csr_pkg::csr_data_t clint_rdata_o,
    input logic               global_int_en_o,
    input csr_pkg::csr_data_t clint_mtvec_o,
    input csr_pkg::csr_data_t clint_mepc_o,
    input csr_pkg::csr_data_t clint_mstatus_o,
    input csr_pkg::csr_data_t clint_mie_o
);

    a_gie_low_in_reset: assert property (@(posedge clk) !rst_n_i |-> !global_int_en_o)
        else $error("global interrupt enable high during reset");

    a_outputs_known: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$isunknown({ex_rdata_o, clint_rdata_o, global_int_en_o, clint_mtvec_o,
                     clint_mepc_o, clint_mstatus_o, clint_mie_o}))
        else $error("unknown value on a CSR output");

    // no mepc write on either port keeps the output
    a_mepc_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(ex_we_i && ex_waddr_i == csr_pkg::CSR_MEPC) &&
        !(clint_we_i && clint_waddr_i == csr_pkg::CSR_MEPC) |=> $stable(clint_mepc_o))
        else $error("mepc changed without a write");

endmodule

bind csr_top csr_assertions assertions_i (.*);

`default_nettype wire

// ==== verification/tb_top.sv ====
// CSR unit testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    localparam csr_pkg::csr_data_t MISA = 32'h4000_1100;

    logic clk, rst_n, inst_valid;
    logic ex_we, clint_we, gie;
    csr_pkg::csr_addr_t ex_raddr, ex_waddr, clint_raddr, clint_waddr;
    csr_pkg::csr_data_t ex_wdata, clint_wdata, ex_rdata, clint_rdata;
    csr_pkg::csr_data_t mtvec, mepc, mstatus, mie;
    logic [31:0] rnd_state = 32'd97;
    int tests_run = 0;
    int err_mark  = 0;

    // kept registers plus one unknown address
    csr_pkg::csr_addr_t addr_list [15] = '{12'h300, 12'h301, 12'h304, 12'h305, 12'h340,
        12'h341, 12'h342, 12'h343, 12'hB00, 12'hB02, 12'hB80, 12'hB82, 12'hC01, 12'hC81,
        12'h7C0};

    tb_clock_gen #(.PERIOD(8), .RESET_CYCLES(4)) clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    csr_top #(.MISA_VALUE(MISA)) dut_i (
        .clk(clk), .rst_n_i(rst_n), .inst_valid_i(inst_valid),
        .ex_we_i(ex_we), .ex_raddr_i(ex_raddr), .ex_waddr_i(ex_waddr),
        .ex_wdata_i(ex_wdata), .ex_rdata_o(ex_rdata),
        .clint_we_i(clint_we), .clint_raddr_i(clint_raddr), .clint_waddr_i(clint_waddr),
        .clint_wdata_i(clint_wdata), .clint_rdata_o(clint_rdata),
        .global_int_en_o(gie), .clint_mtvec_o(mtvec), .clint_mepc_o(mepc),
        .clint_mstatus_o(mstatus), .clint_mie_o(mie)
    );

    tb_checker #(.MISA_VALUE(MISA)) chk_i (
        .clk(clk), .rst_n_i(rst_n), .inst_valid_i(inst_valid),
        .ex_we_i(ex_we), .ex_raddr_i(ex_raddr), .ex_waddr_i(ex_waddr), .ex_wdata_i(ex_wdata),
        .clint_we_i(clint_we), .clint_raddr_i(clint_raddr), .clint_waddr_i(clint_waddr),
        .clint_wdata_i(clint_wdata), .ex_rdata_i(ex_rdata), .clint_rdata_i(clint_rdata),
        .global_int_en_i(gie), .clint_mtvec_i(mtvec), .clint_mepc_i(mepc),
        .clint_mstatus_i(mstatus), .clint_mie_i(mie)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        rnd_state = xorshift32(rnd_state);
        r = rnd_state;
    endtask

    // one cycle of stimulus set up on the falling edge
    task automatic drive(input logic ewe, input csr_pkg::csr_addr_t ewa,
            input csr_pkg::csr_data_t ewd, input csr_pkg::csr_addr_t era,
            input logic cwe, input csr_pkg::csr_addr_t cwa,
            input csr_pkg::csr_data_t cwd, input csr_pkg::csr_addr_t cra);
        @(negedge clk);
        ex_we       = ewe;
        ex_waddr    = ewa;
        ex_wdata    = ewd;
        ex_raddr    = era;
        clint_we    = cwe;
        clint_waddr = cwa;
        clint_wdata = cwd;
        clint_raddr = cra;
    endtask

    // the last driven cycle is checked before the count is read
    task automatic finish_test(input string name);
        @(negedge clk);
        tests_run++;
        $display("test %s done, %0d errors", name, chk_i.error_count - err_mark);
        err_mark = chk_i.error_count;
    endtask

    initial begin
        logic [31:0] r1, r2, r3;
        int waited;
        inst_valid  = 1'b0;
        ex_we       = 1'b0;
        ex_raddr    = '0;
        ex_waddr    = '0;
        ex_wdata    = '0;
        clint_we    = 1'b0;
        clint_raddr = '0;
        clint_waddr = '0;
        clint_wdata = '0;

        waited = 0;
        while (rst_n !== 1'b1 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("sim failed");
            $finish;
        end else begin
            for (int i = 0; i < 8; i++)
                drive(0, 0, 0, addr_list[i], 0, 0, 0, addr_list[i]);
            finish_test("reset_values");

            for (int i = 0; i < 8; i++) begin
                next_rand(r1);
                if (i % 2 == 0) drive(1, addr_list[i], r1, 12'h7C0, 0, 0, 0, 12'h7C0);
                else drive(0, 0, 0, 12'h7C0, 1, addr_list[i], r1, 12'h7C0);
                drive(0, 0, 0, addr_list[i], 0, 0, 0, addr_list[i]);
            end
            drive(0, 0, 0, 12'h300, 1, 12'h300, 32'h0000_0008, 12'h300);
            drive(0, 0, 0, 12'h300, 0, 0, 0, 12'h300);
            finish_test("write_read");

            next_rand(r1);
            next_rand(r2);
            drive(1, 12'h341, r1, 12'h341, 1, 12'h341, r2, 12'h341);
            drive(1, 12'h342, r2, 12'h341, 1, 12'h343, r1, 12'h343);
            drive(0, 0, 0, 12'h342, 0, 0, 0, 12'h343);
            finish_test("write_collision");

            next_rand(r1);
            drive(1, 12'h340, r1, 12'h340, 0, 0, 0, 12'h340);
            next_rand(r1);
            drive(0, 0, 0, 12'h305, 1, 12'h305, r1, 12'h305);
            drive(0, 0, 0, 12'h340, 0, 0, 0, 12'h305);
            finish_test("read_bypass");

            for (int i = 0; i < 12; i++) begin
                next_rand(r3);
                drive(0, 0, 0, (i < 6) ? 12'hB00 : 12'hB02, 0, 0, 0, 12'hC01);
                inst_valid = r3[0];
            end
            next_rand(r1);
            next_rand(r2);
            drive(1, 12'hB80, r1, 12'hB80, 1, 12'hB02, r2, 12'hB02);
            drive(1, 12'hB00, 32'hFFFF_FFFE, 12'hB00, 1, 12'hB82, r1, 12'hB82);
            for (int i = 0; i < 6; i++) begin
                next_rand(r3);
                drive(0, 0, 0, (i % 2) ? 12'hB80 : 12'hB00, 0, 0, 0, 12'hB02);
                inst_valid = r3[0];
            end
            finish_test("counters");

            drive(0, 0, 0, 12'h7C0, 0, 0, 0, 12'hF14);
            drive(1, 12'h7C0, 32'h1234_5678, 12'h7C0, 1, 12'hF14, 32'h9ABC_DEF0, 12'hF14);
            finish_test("unknown_address");

            for (int i = 0; i < 40; i++) begin
                next_rand(r1);
                next_rand(r2);
                next_rand(r3);
                drive(r3[0], addr_list[r1 % 15], r2, addr_list[r3[11:8] % 15],
                      r3[1], addr_list[r2 % 15], r1, addr_list[r3[15:12] % 15]);
                inst_valid = r3[2];
            end
            drive(0, 0, 0, 0, 0, 0, 0, 0);
            finish_test("random_traffic");

            $display("tests %0d, checks %0d, errors %0d", tests_run, chk_i.check_count,
                     chk_i.error_count);
            if (chk_i.error_count == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
design/csr_pkg.sv
design/csr_ifs.sv
design/csr_trap_regs.sv
design/csr_counters.sv
design/csr_read_port.sv
design/csr_top.sv
verification/tb_clock_gen.sv
verification/tb_checker.sv
verification/csr_assertions.sv
verification/tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the CSR unit simulation with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_top -f sim.f -o sim_csr

./obj_dir/sim_csr | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
